/* Bender.yml */
package:
  name: fetch_frontend

sources:
  # Package first, then the stages, then the top level
  - rtl/fetch_pkg.sv
  - rtl/fetch_stage_f1.sv
  - rtl/fetch_itlb.sv
  - rtl/fetch_stage_f2.sv
  - rtl/fetch_frontend.sv

  # Simulation only
  - target: test
    files:
      - testbench/fetch_frontend_properties.sv
      - testbench/fetch_frontend_tb.sv

/* rtl/fetch_frontend.sv */
// Instruction fetch front end: F1, ITLB and F2.
// o_tlb_miss is high from reset until a refill covers the reset page.
// A translated PC shows on o_fetch one clock after it is the F1 PC.
// Stall and flush are plain levels. Stall has priority over flush.
module fetch_frontend #(
    parameter int TLB_ENTRIES = 4,
    parameter int IMEM_WORDS  = 256
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Branch redirect
    input  logic                  i_branch_taken,
    input  fetch_pkg::pc_word_t   i_branch_target,

    // Hazard levels
    input  logic                  i_stall,
    input  logic                  i_flush,

    // TLB refill and memory load
    input  fetch_pkg::tlb_fill_s  i_tlb_fill,
    input  fetch_pkg::imem_wr_s   i_imem_wr,

    // Fetch result and miss report
    output fetch_pkg::fetch_out_s o_fetch,
    output logic                  o_tlb_miss,
    output fetch_pkg::vpn_t       o_miss_vpn
);

    import fetch_pkg::*;

    vpn_t      f1_vpn;
    logic      tlb_hit;
    ppn_t      tlb_ppn;
    f1_to_f2_s f1_to_f2;

    // PC and address build
    fetch_stage_f1 u_f1 (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_branch_taken  (i_branch_taken),
        .i_branch_target (i_branch_target),
        .i_stall         (i_stall),
        .o_vpn           (f1_vpn),
        .i_tlb_hit       (tlb_hit),
        .i_tlb_ppn       (tlb_ppn),
        .o_stage_ready   (),
        .o_f1_to_f2      (f1_to_f2)
    );

    // Same-cycle translation
    fetch_itlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_itlb (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_vpn      (f1_vpn),
        .o_hit      (tlb_hit),
        .o_ppn      (tlb_ppn),
        .o_miss     (o_tlb_miss),
        .o_miss_vpn (o_miss_vpn),
        .i_fill     (i_tlb_fill)
    );

    // Memory read and output register
    fetch_stage_f2 #(
        .IMEM_WORDS (IMEM_WORDS)
    ) u_f2 (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_f1_to_f2 (f1_to_f2),
        .i_imem_wr  (i_imem_wr),
        .o_fetch    (o_fetch)
    );

endmodule : fetch_frontend

/* rtl/fetch_itlb.sv */
// Fully associative instruction TLB.
// Lookup is combinational. A refill is visible the cycle after its strobe.
// A refill for a vpn already present overwrites that entry. Otherwise it
// goes to the round-robin pointer, which then advances.
// No permission bits and no page-table walk: misses are refilled from outside.
module fetch_itlb #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,

    // Lookup
    input  fetch_pkg::vpn_t      i_vpn,
    output logic                 o_hit,
    output fetch_pkg::ppn_t      o_ppn,

    // Miss report
    output logic                 o_miss,
    output fetch_pkg::vpn_t      o_miss_vpn,

    // Refill
    input  fetch_pkg::tlb_fill_s i_fill
);

    import fetch_pkg::*;

    // Keep the pointer at least one bit wide
    localparam int PTR_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    logic [TLB_ENTRIES-1:0] valid_q;
    vpn_t                   vpn_q [TLB_ENTRIES];
    ppn_t                   ppn_q [TLB_ENTRIES];
    logic [PTR_W-1:0]       rr_ptr_q;

    logic [TLB_ENTRIES-1:0] hit_vec;
    logic                   fill_match;
    logic [PTR_W-1:0]       fill_idx;
    logic [PTR_W-1:0]       wr_idx;

    // Parallel compare, at most one entry matches
    always_comb begin
        o_ppn = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit_vec[i] = valid_q[i] && (vpn_q[i] == i_vpn);
            if (hit_vec[i]) begin
                o_ppn = o_ppn | ppn_q[i];
            end
        end
    end

    assign o_hit      = |hit_vec;
    assign o_miss     = !o_hit;
    assign o_miss_vpn = i_vpn;

    // Look for an entry already holding the refill page
    always_comb begin
        fill_match = 1'b0;
        fill_idx   = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (valid_q[i] && (vpn_q[i] == i_fill.vpn)) begin
                fill_match = 1'b1;
                fill_idx   = PTR_W'(i);
            end
        end
    end

    assign wr_idx = fill_match ? fill_idx : rr_ptr_q;

    // Control state: valid bits and replacement pointer
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (i_fill.valid) begin
            valid_q[wr_idx] <= 1'b1;
            // Pointer moves only when a new entry is taken
            if (!fill_match) begin
                if (rr_ptr_q == PTR_W'(TLB_ENTRIES - 1)) begin
                    rr_ptr_q <= '0;
                end else begin
                    rr_ptr_q <= rr_ptr_q + PTR_W'(1);
                end
            end
        end
    end

    // Tag and translation payload
    always_ff @(posedge i_clk) begin
        if (i_fill.valid) begin
            vpn_q[wr_idx] <= i_fill.vpn;
            ppn_q[wr_idx] <= i_fill.ppn;
        end
    end

endmodule : fetch_itlb

/* rtl/fetch_pkg.sv */
// Shared types for the instruction fetch front end.
// PCs are word addresses, so the two zero bits of a byte address are dropped.
// Pages are 4 KiB (1024 words), and the physical space is 64 KiB (16 pages).
// Record widths are 25, 47, 47 and 63 bits in declaration order.
package fetch_pkg;

    // Address field widths
    localparam int PC_WORD_W  = 30;
    localparam int PAGE_OFF_W = 10;
    localparam int VPN_W      = PC_WORD_W - PAGE_OFF_W;
    localparam int PPN_W      = 4;
    localparam int PADDR_W    = PPN_W + PAGE_OFF_W + 2;
    // Physical word address width for the memory load port
    localparam int PWORD_W    = PADDR_W - 2;
    localparam int WORD_W     = 32;

    typedef logic [PC_WORD_W-1:0]  pc_word_t;
    typedef logic [VPN_W-1:0]      vpn_t;
    typedef logic [PPN_W-1:0]      ppn_t;
    typedef logic [PAGE_OFF_W-1:0] page_off_t;
    typedef logic [PADDR_W-1:0]    paddr_t;
    typedef logic [PWORD_W-1:0]    pword_t;
    typedef logic [WORD_W-1:0]     word_t;

    // Word 0x400 is byte 0x1000 in reset page vpn 1
    localparam pc_word_t RESET_PC_WORD = pc_word_t'(30'h400);

    // TLB refill strobed by valid for one cycle
    typedef struct packed {
        logic valid;
        vpn_t vpn;
        ppn_t ppn;
    } tlb_fill_s;

    // Instruction memory load
    typedef struct packed {
        logic   we;
        pword_t addr;
        word_t  data;
    } imem_wr_s;

    // Combinational F1 result
    typedef struct packed {
        logic     valid;
        pc_word_t pc_word;
        paddr_t   fetch_addr;
    } f1_to_f2_s;

    // Registered F2 result for decode
    typedef struct packed {
        logic     valid;
        pc_word_t pc_word;
        word_t    instr;
    } fetch_out_s;

endpackage : fetch_pkg

/* rtl/fetch_stage_f1.sv */
// First fetch stage: holds the PC and builds the physical fetch address.
// Translation comes back from the ITLB in the same cycle, so the output
// is combinational from the PC register.
// On a TLB miss the PC holds and the output is invalid. Only a branch
// moves the PC away from a missing page.
// A branch is taken only in an unstalled cycle. The source holds it until then.
module fetch_stage_f1 (
    input  logic                 i_clk,
    input  logic                 i_rst_n,

    // Branch redirect
    input  logic                 i_branch_taken,
    input  fetch_pkg::pc_word_t  i_branch_target,

    // Hazard level
    input  logic                 i_stall,

    // ITLB lookup
    output fetch_pkg::vpn_t      o_vpn,
    input  logic                 i_tlb_hit,
    input  fetch_pkg::ppn_t      i_tlb_ppn,

    // PC advances this cycle
    output logic                 o_stage_ready,

    // To F2
    output fetch_pkg::f1_to_f2_s o_f1_to_f2
);

    import fetch_pkg::*;

    pc_word_t  pc_q;
    pc_word_t  next_pc;
    pc_word_t  seq_pc;
    page_off_t page_off;

    // Sequential successor, wraps at the top of the space
    assign seq_pc = pc_q + pc_word_t'(1);

    // Branch wins over the sequential step
    always_comb begin
        if (i_branch_taken) begin
            next_pc = i_branch_target;
        end else begin
            next_pc = seq_pc;
        end
    end

    // Advance when unstalled and either translated or redirected
    assign o_stage_ready = !i_stall && (i_tlb_hit || i_branch_taken);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc_q <= RESET_PC_WORD;
        end else if (o_stage_ready) begin
            pc_q <= next_pc;
        end
    end

    // Split the PC into page number and word offset
    assign o_vpn    = pc_q[PC_WORD_W-1:PAGE_OFF_W];
    assign page_off = pc_q[PAGE_OFF_W-1:0];

    // Physical byte address from the translated page
    always_comb begin
        o_f1_to_f2.valid      = i_tlb_hit;
        o_f1_to_f2.pc_word    = pc_q;
        o_f1_to_f2.fetch_addr = {i_tlb_ppn, page_off, 2'b00};
    end

endmodule : fetch_stage_f1

/* rtl/fetch_stage_f2.sv */
// Second fetch stage: instruction memory and the registered output to decode.
// IMEM_WORDS must be a power of two and no larger than the physical space.
// Higher physical word address bits are ignored, so the memory aliases.
// A load-port write lands at the clock edge. A fetch of the same word in that
// cycle still returns the old contents.
// Stall holds the output register. Flush loads an invalid slot.
module fetch_stage_f2 #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Hazard levels
    input  logic                  i_stall,
    input  logic                  i_flush,

    // From F1
    input  fetch_pkg::f1_to_f2_s  i_f1_to_f2,

    // Memory load port
    input  fetch_pkg::imem_wr_s   i_imem_wr,

    // To decode
    output fetch_pkg::fetch_out_s o_fetch
);

    import fetch_pkg::*;

    localparam int IDX_W = $clog2(IMEM_WORDS);

    word_t             mem [IMEM_WORDS];
    pword_t            rd_word_addr;
    logic [IDX_W-1:0]  rd_idx;
    logic [IDX_W-1:0]  wr_idx;
    word_t             rd_data;

    logic              valid_q;
    pc_word_t          pc_q;
    word_t             instr_q;

    // Byte address to word index
    assign rd_word_addr = i_f1_to_f2.fetch_addr[PADDR_W-1:2];
    assign rd_idx       = rd_word_addr[IDX_W-1:0];
    assign wr_idx       = i_imem_wr.addr[IDX_W-1:0];

    // Load port
    always_ff @(posedge i_clk) begin
        if (i_imem_wr.we) begin
            mem[wr_idx] <= i_imem_wr.data;
        end
    end

    // Asynchronous read, registered below
    assign rd_data = mem[rd_idx];

    // Slot valid: cleared by reset and flush, held by stall
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (!i_stall) begin
            valid_q <= i_f1_to_f2.valid && !i_flush;
        end
    end

    // Payload follows the same enable
    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            pc_q    <= i_f1_to_f2.pc_word;
            instr_q <= rd_data;
        end
    end

    always_comb begin
        o_fetch.valid   = valid_q;
        o_fetch.pc_word = pc_q;
        o_fetch.instr   = instr_q;
    end

endmodule : fetch_stage_f2

/* testbench/fetch_frontend_properties.sv */
// Concurrent checks bound to the fetch front end top level.
// Sampled on the rising clock edge.
// fail_count counts failed assertions for the testbench.
module fetch_frontend_properties (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_stall,
    input  logic                  i_tlb_miss,
    input  fetch_pkg::fetch_out_s i_fetch
);

    int fail_count = 0;

    // Reset leaves an empty output slot
    a_reset_clears_valid: assert property (
        @(posedge i_clk) !i_rst_n |=> !i_fetch.valid
    ) else begin
        $error("o_fetch.valid high in the cycle after reset");
        fail_count++;
    end

    // Output register holds across a stalled edge
    a_stall_holds_fetch: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_stall |=> $stable(i_fetch)
    ) else begin
        $error("o_fetch changed across a stalled cycle");
        fail_count++;
    end

    // Untranslated PC never reaches decode
    a_miss_gives_bubble: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_tlb_miss && !i_stall) |=> !i_fetch.valid
    ) else begin
        $error("o_fetch valid after an unstalled TLB miss");
        fail_count++;
    end

endmodule : fetch_frontend_properties

/* testbench/fetch_frontend_tb.sv */
// Directed testbench for the fetch front end with default parameters.
// Inputs change on the falling clock edge and outputs are checked there too.
// The reference model keeps the TLB map and the memory image.
// Test pages must fit in the model map table (MAP_MAX entries).
// Pages used are the reset page, vpn 3 and vpn 4.
module fetch_frontend_tb;

    import fetch_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int IMEM_WORDS   = 256;
    localparam int MAP_MAX      = 8;
    localparam vpn_t RESET_VPN  = vpn_t'(RESET_PC_WORD >> PAGE_OFF_W);

    // Cycles of reset, miss check, memory load, refill, branch,
    // stall, flush and page crossing
    localparam int TEST_CYCLES    = RESET_CYCLES + 4 + IMEM_WORDS + 9 + 8 + 8 + 5 + 16;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 64;

    logic       clk;
    logic       rst_n;
    logic       branch_taken;
    pc_word_t   branch_target;
    logic       stall;
    logic       flush;
    tlb_fill_s  tlb_fill;
    imem_wr_s   imem_wr;
    fetch_out_s fetch_out;
    logic       tlb_miss;
    vpn_t       miss_vpn;

    // Reference model state
    word_t      mem_img [IMEM_WORDS];
    vpn_t       map_vpn [MAP_MAX];
    ppn_t       map_ppn [MAP_MAX];
    int         map_count;
    pc_word_t   exp_pc;

    int         cycle_count;

    fetch_frontend dut0 (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .i_stall         (stall),
        .i_flush         (flush),
        .i_tlb_fill      (tlb_fill),
        .i_imem_wr       (imem_wr),
        .o_fetch         (fetch_out),
        .o_tlb_miss      (tlb_miss),
        .o_miss_vpn      (miss_vpn)
    );

    bind fetch_frontend fetch_frontend_properties u_props (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (i_stall),
        .i_tlb_miss (o_tlb_miss),
        .i_fetch    (o_fetch)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "Timeout");
        end
    end

    // Property failure ends the run at once
    always @(dut0.u_props.fail_count) begin
        if (dut0.u_props.fail_count != 0) begin
            $display("ERROR: a bound property assertion failed at time %0t", $time);
            $display("RESULT: FAIL");
            $fatal(1, "Property failure");
        end
    end

    task automatic report_mismatch(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "Check failed");
    endtask

    task automatic next_cycle;
        @(negedge clk);
    endtask

    // Translation as software sees it
    function automatic ppn_t lookup_ppn(input vpn_t vpn);
        ppn_t ppn;
        ppn = 'x;
        for (int i = 0; i < map_count; i++) begin
            if (map_vpn[i] == vpn) begin
                ppn = map_ppn[i];
            end
        end
        return ppn;
    endfunction

    // Word at the translated index with memory aliasing every IMEM_WORDS
    function automatic word_t ref_instr(input pc_word_t pc);
        ppn_t   ppn;
        pword_t pword;
        int     idx;
        ppn   = lookup_ppn(pc[PC_WORD_W-1:PAGE_OFF_W]);
        pword = {ppn, pc[PAGE_OFF_W-1:0]};
        idx   = int'(pword) % IMEM_WORDS;
        return mem_img[idx];
    endfunction

    // Same vpn replaces its mapping
    task automatic map_add(input vpn_t vpn, input ppn_t ppn);
        bit found;
        found = 1'b0;
        for (int i = 0; i < map_count; i++) begin
            if (map_vpn[i] == vpn) begin
                map_ppn[i] = ppn;
                found      = 1'b1;
            end
        end
        if (!found) begin
            map_vpn[map_count] = vpn;
            map_ppn[map_count] = ppn;
            map_count++;
        end
    endtask

    // One-cycle strobe that the caller clears after the edge
    task automatic drive_refill(input vpn_t vpn, input ppn_t ppn);
        tlb_fill.valid = 1'b1;
        tlb_fill.vpn   = vpn;
        tlb_fill.ppn   = ppn;
        map_add(vpn, ppn);
    endtask

    task automatic verify_fetch(input pc_word_t pc);
        word_t exp_instr;
        exp_instr = ref_instr(pc);
        assert (fetch_out.valid === 1'b1)
            else report_mismatch($sformatf("valid low, expected PC word 0x%0h", pc));
        assert (fetch_out.pc_word === pc)
            else report_mismatch($sformatf("PC word 0x%0h, expected 0x%0h",
                                           fetch_out.pc_word, pc));
        assert (fetch_out.instr === exp_instr)
            else report_mismatch($sformatf("instr 0x%08h at PC word 0x%0h, expected 0x%08h",
                                           fetch_out.instr, pc, exp_instr));
    endtask

    task automatic bubble_check(input string where);
        assert (fetch_out.valid === 1'b0)
            else report_mismatch($sformatf("%s: valid high with PC word 0x%0h",
                                           where, fetch_out.pc_word));
    endtask

    // Consecutive slots starting at exp_pc
    task automatic run_sequential(input int n);
        repeat (n) begin
            next_cycle;
            verify_fetch(exp_pc);
            exp_pc = exp_pc + pc_word_t'(1);
        end
    endtask

    // Branch with a flush of the slot behind it
    task automatic redirect(input pc_word_t target);
        branch_taken  = 1'b1;
        branch_target = target;
        flush         = 1'b1;
        next_cycle;
        branch_taken  = 1'b0;
        flush         = 1'b0;
        bubble_check("branch slot");
        exp_pc = target;
    endtask

    task automatic reset_and_miss;
        repeat (4) begin
            assert (tlb_miss === 1'b1)
                else report_mismatch("o_tlb_miss low with an empty TLB");
            assert (miss_vpn === RESET_VPN)
                else report_mismatch($sformatf("miss vpn 0x%0h, expected 0x%0h",
                                               miss_vpn, RESET_VPN));
            bubble_check("after reset");
            next_cycle;
        end
    endtask

    // Random image through the load port while the TLB is empty
    task automatic load_memory;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem_wr.we   = 1'b1;
            imem_wr.addr = pword_t'(i);
            imem_wr.data = $urandom;
            mem_img[i]   = imem_wr.data;
            next_cycle;
            bubble_check("memory load");
        end
        imem_wr.we = 1'b0;
    endtask

    task automatic refill_and_sequential;
        drive_refill(RESET_VPN, 4'h5);
        next_cycle;
        tlb_fill.valid = 1'b0;
        assert (tlb_miss === 1'b0)
            else report_mismatch("o_tlb_miss high after refill of the reset page");
        bubble_check("refill cycle");
        exp_pc = RESET_PC_WORD;
        run_sequential(8);
    endtask

    task automatic branch_redirect;
        // Map the target page while fetch runs on
        drive_refill(vpn_t'(3), 4'h2);
        next_cycle;
        tlb_fill.valid = 1'b0;
        verify_fetch(exp_pc);
        exp_pc = exp_pc + pc_word_t'(1);
        redirect(pc_word_t'(30'hC10));
        run_sequential(6);
    endtask

    task automatic stall_hold;
        fetch_out_s held;
        held  = fetch_out;
        stall = 1'b1;
        repeat (4) begin
            next_cycle;
            assert (fetch_out === held)
                else report_mismatch($sformatf("o_fetch moved under stall to PC word 0x%0h",
                                               fetch_out.pc_word));
        end
        stall = 1'b0;
        run_sequential(4);
    endtask

    task automatic flush_bubble;
        flush = 1'b1;
        next_cycle;
        flush = 1'b0;
        bubble_check("flush slot");
        // Flushed PC is gone since F1 already moved on
        exp_pc = exp_pc + pc_word_t'(1);
        run_sequential(4);
    endtask

    task automatic page_cross_miss;
        vpn_t next_vpn;
        next_vpn = vpn_t'(4);
        redirect(pc_word_t'(30'hFFC));
        run_sequential(4);
        // F1 now sits on the first word of the unmapped page
        repeat (3) begin
            assert (tlb_miss === 1'b1)
                else report_mismatch("o_tlb_miss low at the page crossing");
            assert (miss_vpn === next_vpn)
                else report_mismatch($sformatf("miss vpn 0x%0h, expected 0x%0h",
                                               miss_vpn, next_vpn));
            next_cycle;
            bubble_check("page miss");
        end
        drive_refill(next_vpn, 4'h7);
        next_cycle;
        tlb_fill.valid = 1'b0;
        bubble_check("refill of crossed page");
        assert (tlb_miss === 1'b0)
            else report_mismatch("o_tlb_miss high after refill of the crossed page");
        run_sequential(6);
    endtask

    initial begin
        branch_taken  = 1'b0;
        branch_target = '0;
        stall         = 1'b0;
        flush         = 1'b0;
        tlb_fill      = '0;
        imem_wr       = '0;
        map_count     = 0;
        exp_pc        = RESET_PC_WORD;
        cycle_count   = 0;
        void'($urandom(4344));

        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        reset_and_miss;
        load_memory;
        refill_and_sequential;
        branch_redirect;
        stall_hold;
        flush_bubble;
        page_cross_miss;

        // One more edge so the last property samples complete
        next_cycle;
        if (dut0.u_props.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : fetch_frontend_tb

/* vlog.f */
rtl/fetch_pkg.sv
rtl/fetch_stage_f1.sv
rtl/fetch_itlb.sv
rtl/fetch_stage_f2.sv
rtl/fetch_frontend.sv
testbench/fetch_frontend_properties.sv
testbench/fetch_frontend_tb.sv
